/* src/regfile_route_cfg.svh */
// widths and pipeline depths are fixed at compile time and RR_MEM_W must equal RR_DAT_W
`ifndef REGFILE_ROUTE_CFG_SVH
`define REGFILE_ROUTE_CFG_SVH

// ----------------------------------------------------------------------------
// data path widths
// ----------------------------------------------------------------------------

// register word
`define RR_DAT_W 16
// memory word, same as the register word
`define RR_MEM_W 16
// data memory address
`define RR_ADDR_W 10

// ----------------------------------------------------------------------------
// scheduling
// ----------------------------------------------------------------------------

// write delay counter
`define RR_DLY_W 4
// one select bit per register
`define RR_NUM_GPR 8

// ----------------------------------------------------------------------------
// pipeline depths, counted in t_cs cycles
// ----------------------------------------------------------------------------

`define RR_IMM_STAGES 2
`define RR_MEM_STAGES 7
`define RR_INDIR_STAGES 2

`endif

/* src/regfile_route_pkg.sv */
// types follow the widths in the cfg header, so a width change there resizes every port
`include "regfile_route_cfg.svh"

package regfile_route_pkg;

	// ------------------------------------------------------------------------
	// data words
	// ------------------------------------------------------------------------

	// general register contents
	typedef logic [`RR_DAT_W-1:0] gpr_word_t;

	// data memory contents
	typedef logic [`RR_MEM_W-1:0] mem_word_t;

	// data memory address
	typedef logic [`RR_ADDR_W-1:0] mem_addr_t;

	// ------------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------------

	// one-hot register select, bit n picks register n
	typedef logic [`RR_NUM_GPR-1:0] gpr_sel_t;

	// write delay count
	typedef logic [`RR_DLY_W-1:0] delay_t;

endpackage

/* src/stage_delay.sv */
// DEPTH must be one or more, and the whole chain holds while advance is low
module stage_delay #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1,
	parameter payload_t RESET_VALUE = payload_t'(0)
) (
	input  logic     clk,
	input  logic     reset_b,
	input  logic     advance,
	input  payload_t d,
	output payload_t q
);

	// stage 0 takes d, the last stage drives q
	payload_t chain_q [DEPTH];

	if (DEPTH < 1) begin : g_depth_check
		$error("stage_delay needs DEPTH of at least one");
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			for (int i = 0; i < DEPTH; i++) begin
				chain_q[i] <= RESET_VALUE;
			end
		end else if (advance) begin
			chain_q[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				chain_q[i] <= chain_q[i-1];
			end
		end
	end

	assign q = chain_q[DEPTH-1];

endmodule

/* src/select_sched.sv */
// selects are one-hot, and write selects are combinational from the counter and halt state
module select_sched (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic                        t_cs,
	input  logic                        halt_req,
	input  logic                        alu_done,
	input  regfile_route_pkg::delay_t   delay,
	input  logic                        delay_sel,
	input  regfile_route_pkg::gpr_sel_t src_rsel,
	input  regfile_route_pkg::gpr_sel_t src_wsel,
	input  regfile_route_pkg::gpr_sel_t dst_rsel,
	input  regfile_route_pkg::gpr_sel_t dst_wsel,
	input  logic                        dst_mod_wsel,
	output regfile_route_pkg::gpr_sel_t bus1_rsel,
	output regfile_route_pkg::gpr_sel_t bus2_rsel,
	output regfile_route_pkg::gpr_sel_t gprf_wsel,
	output logic                        gprf_mod_wsel
);

	// captured decoder selects
	regfile_route_pkg::gpr_sel_t src_rsel_q;
	regfile_route_pkg::gpr_sel_t dst_rsel_q;
	regfile_route_pkg::gpr_sel_t src_wsel_q;
	regfile_route_pkg::gpr_sel_t dst_wsel_q;
	logic                        dst_mod_wsel_q;

	// write scheduling
	regfile_route_pkg::delay_t   count_q;
	logic                        halt_q;
	logic                        capture;
	logic                        count_zero;
	logic                        count_one;

	assign capture    = t_cs && delay_sel;
	assign count_zero = (count_q == '0);
	assign count_one  = (count_q == regfile_route_pkg::delay_t'(1));

	// ------------------------------------------------------------------------
	// select capture
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			src_rsel_q     <= '0;
			dst_rsel_q     <= '0;
			src_wsel_q     <= '0;
			dst_wsel_q     <= '0;
			dst_mod_wsel_q <= 1'b0;
		end else if (capture) begin
			src_rsel_q     <= src_rsel;
			dst_rsel_q     <= dst_rsel;
			src_wsel_q     <= src_wsel;
			dst_wsel_q     <= dst_wsel;
			dst_mod_wsel_q <= dst_mod_wsel;
		end
	end

	assign bus1_rsel = src_rsel_q;
	assign bus2_rsel = dst_rsel_q;

	// ------------------------------------------------------------------------
	// delay counter and halt
	// ------------------------------------------------------------------------

	// halt at zero pins the count, alu done forces a source write next
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			count_q <= '0;
		end else if (halt_req && count_zero) begin
			count_q <= '0;
		end else if (alu_done) begin
			count_q <= regfile_route_pkg::delay_t'(1);
		end else if (t_cs && !delay_sel) begin
			// wraps past zero
			count_q <= count_q - regfile_route_pkg::delay_t'(1);
		end else if (t_cs && delay_sel) begin
			count_q <= delay;
		end
	end

	// not stalled by t_cs
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			halt_q <= 1'b0;
		end else begin
			halt_q <= halt_req && count_zero;
		end
	end

	// ------------------------------------------------------------------------
	// write select timing
	// ------------------------------------------------------------------------

	// count one writes the source, count zero the destination
	always_comb begin
		gprf_wsel     = '0;
		gprf_mod_wsel = 1'b0;
		if (!halt_q && count_zero) begin
			gprf_wsel     = dst_wsel_q;
			gprf_mod_wsel = dst_mod_wsel_q;
		end else if (!halt_q && count_one) begin
			gprf_wsel     = src_wsel_q;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// at most one register written when the decoder gave one-hot selects
	a_wsel_onehot: assert property (
		@(posedge clk) disable iff (!reset_b)
		($onehot0(src_wsel_q) && $onehot0(dst_wsel_q)) |-> $onehot0(gprf_wsel)
	);

	// a halt at count zero keeps the write port quiet on the next cycle
	a_halt_quiet: assert property (
		@(posedge clk) disable iff (!reset_b)
		(halt_req && count_zero) |=> (gprf_wsel == '0 && !gprf_mod_wsel)
	);

endmodule

/* src/data_steer.sv */
// write data mux uses live mem_rdata, so memory must return data in the cycle the enable lands
`include "regfile_route_cfg.svh"

module data_steer (
	input  logic                          clk,
	input  logic                          reset_b,
	input  logic                          t_cs,
	input  logic                          imm_en,
	input  regfile_route_pkg::gpr_word_t  imm,
	input  logic                          mem_en_b,
	input  logic                          dst_indir_sel,
	input  regfile_route_pkg::mem_word_t  mem_rdata,
	input  regfile_route_pkg::gpr_word_t  gprf_rdata1,
	input  regfile_route_pkg::gpr_word_t  gprf_rdata2,
	output regfile_route_pkg::gpr_word_t  gprf_wdata,
	output regfile_route_pkg::mem_word_t  mem_wdata,
	output regfile_route_pkg::mem_addr_t  mem_addr
);

	regfile_route_pkg::gpr_word_t rdata1_q;
	regfile_route_pkg::gpr_word_t rdata2_q;
	regfile_route_pkg::gpr_word_t imm_q;
	logic                         imm_en_q;
	logic                         mem_en_b_q;
	logic                         indir_q;

	if (`RR_MEM_W != `RR_DAT_W) begin : g_width_check
		$error("memory word and register word widths differ");
	end

	// ------------------------------------------------------------------------
	// register file read capture, one stage
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			rdata1_q <= '0;
			rdata2_q <= '0;
		end else if (t_cs) begin
			rdata1_q <= gprf_rdata1;
			rdata2_q <= gprf_rdata2;
		end
	end

	// ------------------------------------------------------------------------
	// decoder controls, each behind its own depth
	// ------------------------------------------------------------------------

	stage_delay #(
		.payload_t   (regfile_route_pkg::gpr_word_t),
		.DEPTH       (`RR_IMM_STAGES),
		.RESET_VALUE ('0)
	) i_imm_dly (
		.clk     (clk),
		.reset_b (reset_b),
		.advance (t_cs),
		.d       (imm),
		.q       (imm_q)
	);

	stage_delay #(
		.payload_t   (logic),
		.DEPTH       (`RR_IMM_STAGES),
		.RESET_VALUE (1'b0)
	) i_imm_en_dly (
		.clk     (clk),
		.reset_b (reset_b),
		.advance (t_cs),
		.d       (imm_en),
		.q       (imm_en_q)
	);

	// active low, so it comes out of reset disabled
	stage_delay #(
		.payload_t   (logic),
		.DEPTH       (`RR_MEM_STAGES),
		.RESET_VALUE (1'b1)
	) i_mem_en_dly (
		.clk     (clk),
		.reset_b (reset_b),
		.advance (t_cs),
		.d       (mem_en_b),
		.q       (mem_en_b_q)
	);

	stage_delay #(
		.payload_t   (logic),
		.DEPTH       (`RR_INDIR_STAGES),
		.RESET_VALUE (1'b0)
	) i_indir_dly (
		.clk     (clk),
		.reset_b (reset_b),
		.advance (t_cs),
		.d       (dst_indir_sel),
		.q       (indir_q)
	);

	// ------------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------------

	// immediate wins over memory, register port 1 is the fallback
	always_comb begin
		if (imm_en_q) begin
			gprf_wdata = imm_q;
		end else if (!mem_en_b_q) begin
			gprf_wdata = mem_rdata;
		end else begin
			gprf_wdata = rdata1_q;
		end
	end

	assign mem_wdata = rdata1_q;
	assign mem_addr  = indir_q ? rdata2_q[`RR_ADDR_W-1:0] : '0;

	// a stalled cycle leaves the memory outputs where they were
	a_mem_hold_on_stall: assert property (
		@(posedge clk) disable iff (!reset_b)
		!t_cs |=> ($stable(mem_addr) && $stable(mem_wdata))
	);

endmodule

/* src/regfile_route_top.sv */
// both stages share t_cs as their only stall, and nothing passes between them
module regfile_route_top (
	input  logic                          clk,
	input  logic                          reset_b,
	input  logic                          t_cs,

	// scheduling controls
	input  logic                          halt_req,
	input  logic                          alu_done,
	input  regfile_route_pkg::delay_t     delay,
	input  logic                          delay_sel,

	// decoder selects
	input  regfile_route_pkg::gpr_sel_t   src_rsel,
	input  regfile_route_pkg::gpr_sel_t   src_wsel,
	input  regfile_route_pkg::gpr_sel_t   dst_rsel,
	input  regfile_route_pkg::gpr_sel_t   dst_wsel,
	input  logic                          dst_mod_wsel,

	// decoder data controls
	input  logic                          imm_en,
	input  regfile_route_pkg::gpr_word_t  imm,
	input  logic                          mem_en_b,
	input  logic                          dst_indir_sel,

	// memory and register file data
	input  regfile_route_pkg::mem_word_t  mem_rdata,
	input  regfile_route_pkg::gpr_word_t  gprf_rdata1,
	input  regfile_route_pkg::gpr_word_t  gprf_rdata2,
	output regfile_route_pkg::gpr_word_t  gprf_wdata,
	output regfile_route_pkg::mem_word_t  mem_wdata,
	output regfile_route_pkg::mem_addr_t  mem_addr,

	// register file selects
	output regfile_route_pkg::gpr_sel_t   bus1_rsel,
	output regfile_route_pkg::gpr_sel_t   bus2_rsel,
	output regfile_route_pkg::gpr_sel_t   gprf_wsel,
	output logic                          gprf_mod_wsel
);

	select_sched i_select_sched (
		.clk           (clk),
		.reset_b       (reset_b),
		.t_cs          (t_cs),
		.halt_req      (halt_req),
		.alu_done      (alu_done),
		.delay         (delay),
		.delay_sel     (delay_sel),
		.src_rsel      (src_rsel),
		.src_wsel      (src_wsel),
		.dst_rsel      (dst_rsel),
		.dst_wsel      (dst_wsel),
		.dst_mod_wsel  (dst_mod_wsel),
		.bus1_rsel     (bus1_rsel),
		.bus2_rsel     (bus2_rsel),
		.gprf_wsel     (gprf_wsel),
		.gprf_mod_wsel (gprf_mod_wsel)
	);

	data_steer i_data_steer (
		.clk           (clk),
		.reset_b       (reset_b),
		.t_cs          (t_cs),
		.imm_en        (imm_en),
		.imm           (imm),
		.mem_en_b      (mem_en_b),
		.dst_indir_sel (dst_indir_sel),
		.mem_rdata     (mem_rdata),
		.gprf_rdata1   (gprf_rdata1),
		.gprf_rdata2   (gprf_rdata2),
		.gprf_wdata    (gprf_wdata),
		.mem_wdata     (mem_wdata),
		.mem_addr      (mem_addr)
	);

endmodule

/* bench/regfile_route_checks.sv */
// compares DUT outputs with the reference model on every clock, and flags the first mismatch
module regfile_route_checks (
	input  logic                         clk,
	input  logic                         reset_b,
	input  logic                         seen_cs,
	input  regfile_route_pkg::gpr_sel_t  bus1_rsel,
	input  regfile_route_pkg::gpr_sel_t  bus2_rsel,
	input  regfile_route_pkg::gpr_sel_t  gprf_wsel,
	input  logic                         gprf_mod_wsel,
	input  regfile_route_pkg::gpr_word_t gprf_wdata,
	input  regfile_route_pkg::mem_word_t mem_wdata,
	input  regfile_route_pkg::mem_addr_t mem_addr,
	input  regfile_route_pkg::gpr_sel_t  exp_bus1_rsel,
	input  regfile_route_pkg::gpr_sel_t  exp_bus2_rsel,
	input  regfile_route_pkg::gpr_sel_t  exp_wsel,
	input  logic                         exp_mod_wsel,
	input  regfile_route_pkg::gpr_word_t exp_wdata,
	input  regfile_route_pkg::mem_word_t exp_mem_wdata,
	input  regfile_route_pkg::mem_addr_t exp_addr,
	output logic                         failed
);

	timeunit 1ns;
	timeprecision 100ps;

	initial failed = 1'b0;

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		failed = 1'b1;
	endtask

	task automatic report_problem(input string what);
		$display("FAILED at %0t: %s", $time, what);
		failed = 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// quiet outputs out of reset
	// ------------------------------------------------------------------------

	a_idle_zero: assert property (@(posedge clk) disable iff (!reset_b)
		!seen_cs |-> (bus1_rsel == '0 && bus2_rsel == '0 && gprf_wsel == '0 &&
			!gprf_mod_wsel && mem_addr == '0 && gprf_wdata == '0))
	else report_problem("an output is not zero after reset and before the first t_cs");

	// ------------------------------------------------------------------------
	// select outputs
	// ------------------------------------------------------------------------

	a_bus1: assert property (@(posedge clk) disable iff (!reset_b)
		bus1_rsel == exp_bus1_rsel)
	else report_mismatch("bus1_rsel", 32'($sampled(bus1_rsel)), 32'($sampled(exp_bus1_rsel)));

	a_bus2: assert property (@(posedge clk) disable iff (!reset_b)
		bus2_rsel == exp_bus2_rsel)
	else report_mismatch("bus2_rsel", 32'($sampled(bus2_rsel)), 32'($sampled(exp_bus2_rsel)));

	a_wsel: assert property (@(posedge clk) disable iff (!reset_b)
		gprf_wsel == exp_wsel)
	else report_mismatch("gprf_wsel", 32'($sampled(gprf_wsel)), 32'($sampled(exp_wsel)));

	a_mod_wsel: assert property (@(posedge clk) disable iff (!reset_b)
		gprf_mod_wsel == exp_mod_wsel)
	else report_mismatch("gprf_mod_wsel", 32'($sampled(gprf_mod_wsel)),
		32'($sampled(exp_mod_wsel)));

	// ------------------------------------------------------------------------
	// data outputs
	// ------------------------------------------------------------------------

	a_wdata: assert property (@(posedge clk) disable iff (!reset_b)
		gprf_wdata == exp_wdata)
	else report_mismatch("gprf_wdata", 32'($sampled(gprf_wdata)), 32'($sampled(exp_wdata)));

	a_mem_wdata: assert property (@(posedge clk) disable iff (!reset_b)
		mem_wdata == exp_mem_wdata)
	else report_mismatch("mem_wdata", 32'($sampled(mem_wdata)), 32'($sampled(exp_mem_wdata)));

	a_mem_addr: assert property (@(posedge clk) disable iff (!reset_b)
		mem_addr == exp_addr)
	else report_mismatch("mem_addr", 32'($sampled(mem_addr)), 32'($sampled(exp_addr)));

endmodule

/* bench/regfile_route_tb.sv */
// random stimulus from seed 48 with t_cs low about a quarter of the time, checked by assertions
`include "regfile_route_cfg.svh"

module regfile_route_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = 3;
	localparam int TEST_CYCLES  = 4000;
	localparam int TIMEOUT_NS   =
		(RESET_CYCLES + IDLE_CYCLES + TEST_CYCLES + 8) * CLK_PERIOD + 400;
	localparam int IMM_LAST   = `RR_IMM_STAGES - 1;
	localparam int MEM_LAST   = `RR_MEM_STAGES - 1;
	localparam int INDIR_LAST = `RR_INDIR_STAGES - 1;

	logic clk;
	logic reset_b;
	logic t_cs;
	logic halt_req;
	logic alu_done;
	logic delay_sel;
	logic dst_mod_wsel;
	logic imm_en;
	logic mem_en_b;
	logic dst_indir_sel;
	logic gprf_mod_wsel;
	logic failed;
	regfile_route_pkg::delay_t    delay;
	regfile_route_pkg::gpr_sel_t  src_rsel;
	regfile_route_pkg::gpr_sel_t  src_wsel;
	regfile_route_pkg::gpr_sel_t  dst_rsel;
	regfile_route_pkg::gpr_sel_t  dst_wsel;
	regfile_route_pkg::gpr_sel_t  bus1_rsel;
	regfile_route_pkg::gpr_sel_t  bus2_rsel;
	regfile_route_pkg::gpr_sel_t  gprf_wsel;
	regfile_route_pkg::gpr_word_t imm;
	regfile_route_pkg::gpr_word_t gprf_rdata1;
	regfile_route_pkg::gpr_word_t gprf_rdata2;
	regfile_route_pkg::gpr_word_t gprf_wdata;
	regfile_route_pkg::mem_word_t mem_rdata;
	regfile_route_pkg::mem_word_t mem_wdata;
	regfile_route_pkg::mem_addr_t mem_addr;

	// reference model state
	logic                         seen_cs;
	logic                         m_mod;
	logic                         m_halt;
	regfile_route_pkg::delay_t    m_count;
	regfile_route_pkg::gpr_sel_t  m_src_rsel;
	regfile_route_pkg::gpr_sel_t  m_dst_rsel;
	regfile_route_pkg::gpr_sel_t  m_src_wsel;
	regfile_route_pkg::gpr_sel_t  m_dst_wsel;
	regfile_route_pkg::gpr_word_t m_rdata1;
	regfile_route_pkg::gpr_word_t m_rdata2;
	regfile_route_pkg::gpr_word_t m_imm_pipe [`RR_IMM_STAGES];
	logic                         m_imm_en_pipe [`RR_IMM_STAGES];
	logic                         m_mem_en_b_pipe [`RR_MEM_STAGES];
	logic                         m_indir_pipe [`RR_INDIR_STAGES];

	// model outputs
	regfile_route_pkg::gpr_sel_t  exp_wsel;
	logic                         exp_mod_wsel;
	regfile_route_pkg::gpr_word_t exp_wdata;
	regfile_route_pkg::mem_addr_t exp_addr;

	regfile_route_top i_dut (.*);

	regfile_route_checks i_checks (
		.clk (clk), .reset_b (reset_b), .seen_cs (seen_cs),
		.bus1_rsel (bus1_rsel), .bus2_rsel (bus2_rsel),
		.gprf_wsel (gprf_wsel), .gprf_mod_wsel (gprf_mod_wsel),
		.gprf_wdata (gprf_wdata), .mem_wdata (mem_wdata), .mem_addr (mem_addr),
		.exp_bus1_rsel (m_src_rsel), .exp_bus2_rsel (m_dst_rsel),
		.exp_wsel (exp_wsel), .exp_mod_wsel (exp_mod_wsel),
		.exp_wdata (exp_wdata), .exp_mem_wdata (m_rdata1), .exp_addr (exp_addr),
		.failed (failed)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	always @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			seen_cs    <= 1'b0;
			m_src_rsel <= '0;
			m_dst_rsel <= '0;
			m_src_wsel <= '0;
			m_dst_wsel <= '0;
			m_mod      <= 1'b0;
			m_count    <= '0;
			m_halt     <= 1'b0;
			m_rdata1   <= '0;
			m_rdata2   <= '0;
			for (int i = 0; i < `RR_IMM_STAGES; i++) begin
				m_imm_pipe[i]    <= '0;
				m_imm_en_pipe[i] <= 1'b0;
			end
			for (int i = 0; i < `RR_MEM_STAGES; i++) begin
				m_mem_en_b_pipe[i] <= 1'b1;
			end
			for (int i = 0; i < `RR_INDIR_STAGES; i++) begin
				m_indir_pipe[i] <= 1'b0;
			end
		end else begin
			if (t_cs) begin
				seen_cs  <= 1'b1;
				m_rdata1 <= gprf_rdata1;
				m_rdata2 <= gprf_rdata2;
				m_imm_pipe[0]      <= imm;
				m_imm_en_pipe[0]   <= imm_en;
				m_mem_en_b_pipe[0] <= mem_en_b;
				m_indir_pipe[0]    <= dst_indir_sel;
				for (int i = 1; i < `RR_IMM_STAGES; i++) begin
					m_imm_pipe[i]    <= m_imm_pipe[i-1];
					m_imm_en_pipe[i] <= m_imm_en_pipe[i-1];
				end
				for (int i = 1; i < `RR_MEM_STAGES; i++) begin
					m_mem_en_b_pipe[i] <= m_mem_en_b_pipe[i-1];
				end
				for (int i = 1; i < `RR_INDIR_STAGES; i++) begin
					m_indir_pipe[i] <= m_indir_pipe[i-1];
				end
			end
			if (t_cs && delay_sel) begin
				m_src_rsel <= src_rsel;
				m_dst_rsel <= dst_rsel;
				m_src_wsel <= src_wsel;
				m_dst_wsel <= dst_wsel;
				m_mod      <= dst_mod_wsel;
			end
			// first matching rule wins
			if (halt_req && m_count == '0) begin
				m_count <= '0;
			end else if (alu_done) begin
				m_count <= regfile_route_pkg::delay_t'(1);
			end else if (t_cs) begin
				m_count <= delay_sel ? delay : m_count - regfile_route_pkg::delay_t'(1);
			end
			m_halt <= halt_req && (m_count == '0);
		end
	end

	always_comb begin
		exp_wsel     = '0;
		exp_mod_wsel = 1'b0;
		if (!m_halt && m_count == '0) begin
			exp_wsel     = m_dst_wsel;
			exp_mod_wsel = m_mod;
		end else if (!m_halt && m_count == regfile_route_pkg::delay_t'(1)) begin
			exp_wsel = m_src_wsel;
		end
		if (m_imm_en_pipe[IMM_LAST]) begin
			exp_wdata = m_imm_pipe[IMM_LAST];
		end else if (!m_mem_en_b_pipe[MEM_LAST]) begin
			exp_wdata = mem_rdata;
		end else begin
			exp_wdata = m_rdata1;
		end
		exp_addr = m_indir_pipe[INDIR_LAST] ? m_rdata2[`RR_ADDR_W-1:0] : '0;
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	function automatic regfile_route_pkg::gpr_sel_t one_hot_sel();
		return regfile_route_pkg::gpr_sel_t'(1) << ($urandom % `RR_NUM_GPR);
	endfunction

	task automatic clear_inputs();
		t_cs = 1'b0;
		halt_req = 1'b0;
		alu_done = 1'b0;
		delay = '0;
		delay_sel = 1'b0;
		src_rsel = '0;
		src_wsel = '0;
		dst_rsel = '0;
		dst_wsel = '0;
		dst_mod_wsel = 1'b0;
		imm_en = 1'b0;
		imm = '0;
		mem_en_b = 1'b1;
		dst_indir_sel = 1'b0;
		mem_rdata = '0;
		gprf_rdata1 = '0;
		gprf_rdata2 = '0;
	endtask

	// short delays so counts one and zero come round often
	task automatic drive_random();
		t_cs = ($urandom % 4) != 0;
		halt_req = ($urandom % 16) == 0;
		alu_done = ($urandom % 16) == 0;
		delay_sel = ($urandom % 8) == 0;
		delay = regfile_route_pkg::delay_t'($urandom % 6);
		src_rsel = one_hot_sel();
		src_wsel = one_hot_sel();
		dst_rsel = one_hot_sel();
		dst_wsel = one_hot_sel();
		dst_mod_wsel = ($urandom % 2) != 0;
		imm_en = ($urandom % 4) == 0;
		imm = regfile_route_pkg::gpr_word_t'($urandom);
		mem_en_b = ($urandom % 4) != 0;
		dst_indir_sel = ($urandom % 2) != 0;
		mem_rdata = regfile_route_pkg::mem_word_t'($urandom);
		gprf_rdata1 = regfile_route_pkg::gpr_word_t'($urandom);
		gprf_rdata2 = regfile_route_pkg::gpr_word_t'($urandom);
	endtask

	initial begin
		void'($urandom(48));
		clear_inputs();
		reset_b = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_b = 1'b1;
		repeat (IDLE_CYCLES) @(posedge clk);
		for (int n = 0; n < TEST_CYCLES; n++) begin
			@(posedge clk);
			#1;
			drive_random();
		end
		repeat (4) @(posedge clk);
		#1;
		if (failed) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "check failures seen");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	always @(posedge failed) begin
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first check failure");
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the stimulus finished");
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

endmodule

/* regfile_route.f */
+incdir+src
src/regfile_route_pkg.sv
src/stage_delay.sv
src/select_sched.sv
src/data_steer.sv
src/regfile_route_top.sv
bench/regfile_route_checks.sv
bench/regfile_route_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := regfile_route_tb
FILELIST  := regfile_route.f
BUILD_DIR := obj_dir
PASS_MSG  := *** TEST PASSED ***

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/regfile_route_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
